//--- src.f
+incdir+test
hdl/main_map_pkg.sv
hdl/main_io_pkg.sv
hdl/main_bus_if.sv
hdl/main_decoder.sv
hdl/main_ram.sv
hdl/main_io.sv
hdl/main_top.sv
test/main_tb.sv

//--- Makefile
# Verilator build and run of the main board testbench

VERILATOR ?= verilator
TOP       ?= main_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/main_ref_model.svh
// Reference model of work RAM, output latches, ROM mapping, input reads and interrupt state
`ifndef MAIN_REF_MODEL_SVH
`define MAIN_REF_MODEL_SVH

logic [7:0]  ram_m [0:4095];
logic [15:0] ram_used [$];
logic [7:0]  snd_m;
logic [7:0]  vbank_m;
logic        prio_m;
logic [3:0]  bank_m;
logic        irq_m;

task automatic reset_model();
    snd_m   = 8'h00;
    vbank_m = 8'h00;
    prio_m  = 1'b0;
    bank_m  = 4'h0;
    irq_m   = 1'b0;
endtask

// CPU memory map
function automatic region_e addr_region(input logic [15:0] a);
    if (a <= 16'h000F)
        return reg_io;
    if (a <= 16'h07FF)
        return reg_gfx1;
    if (a <= 16'h0FFF)
        return reg_gfx2;
    if (a <= 16'h10FF)
        return reg_pal;
    if (a >= 16'h1800 && a <= 16'h27FF)
        return reg_ram;
    if (a >= 16'h6000)
        return reg_rom_fix;
    if (a >= 16'h4000)
        return reg_rom_bank;
    return reg_none;
endfunction

// Fixed ROM is one to one and the banked window sits at 0x10000 plus 8 KB per bank
function automatic logic [17:0] map_rom_addr(input logic [15:0] a, input logic [3:0] bank);
    if (a >= 16'h6000)
        return {2'b00, a};
    return 18'h10000 + {1'b0, bank, a[12:0]};
endfunction

// Responder byte where every address bit takes part
function automatic logic [7:0] rom_byte(input logic [17:0] ra);
    return ra[7:0] ^ ra[15:8] ^ {ra[17:16], ra[17:16], 4'h6};
endfunction

function automatic logic [7:0] expected_io_read(input logic [3:0] off);
    case (off)
        4'h0:    return {3'b111, service, start_button, coin_input};
        4'h1:    return {2'b11, joystick1};
        4'h2:    return {2'b11, joystick2};
        4'h3:    return dipsw_a;
        4'h4:    return dipsw_b;
        4'h5:    return {4'hF, dipsw_c};
        default: return 8'hFF;
    endcase
endfunction

function automatic logic [7:0] predict_read(input logic [15:0] a);
    logic [11:0] ri;
    ri = 12'(a - 16'h1800);
    case (addr_region(a))
        reg_io:       return expected_io_read(a[3:0]);
        reg_gfx1:     return gfx1_dout;
        reg_gfx2:     return gfx2_dout;
        reg_pal:      return pal_dout;
        reg_ram:      return ram_m[ri];
        reg_rom_bank,
        reg_rom_fix:  return rom_byte(map_rom_addr(a, bank_m));
        default:      return 8'hFF;
    endcase
endfunction

task automatic record_write(input logic [15:0] a, input logic [7:0] d);
    logic [11:0] ri;
    ri = 12'(a - 16'h1800);
    if (addr_region(a) == reg_ram) begin
        ram_m[ri] = d;
        ram_used.push_back(a);
    end else if (addr_region(a) == reg_io) begin
        case (a[3:0])
            4'h8:    snd_m = d;
            4'h9:    vbank_m = d;
            4'hA:    prio_m = d[0];
            4'hB:    bank_m = d[3:0];
            4'hC:    irq_m = 1'b0;
            default: ;
        endcase
    end
endtask

`endif

//--- test/main_tb.sv
// Testbench for the main board with random CPU cycles, a ROM responder and a reference model
`timescale 1ns/1ns

module main_tb;
    import main_map_pkg::*;

    localparam int n_trans     = 400;
    localparam int cycle_limit = n_trans * 12;

    logic        clk = 1'b0;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic        snd_irq;
    logic [7:0]  snd_latch;
    logic [17:0] rom_addr;
    logic        rom_cs;
    logic [7:0]  rom_data = 8'h00;
    logic        rom_ok = 1'b0;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic [5:0]  joystick1;
    logic [5:0]  joystick2;
    logic        service;
    logic [15:0] cpu_addr;
    logic        cpu_rnw;
    logic [7:0]  cpu_dout;
    logic        gfx_irqn;
    logic        gfx1_cs;
    logic        gfx2_cs;
    logic        pal_cs;
    logic [7:0]  video_bank;
    logic        prio_latch;
    logic [7:0]  gfx1_dout;
    logic [7:0]  gfx2_dout;
    logic [7:0]  pal_dout;
    logic        irq;
    logic        dip_pause;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [3:0]  dipsw_c;
    int          rom_delay;
    int          rom_wait = 0;
    logic        rom_pending = 1'b0;
    int          cycle_cnt = 0;

    `include "main_ref_model.svh"

    main_top main_top_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // ROM responder answers after rom_delay extra cycles
    always @(posedge clk) begin
        if (rom_ok) begin
            rom_ok      <= 1'b0;
            rom_pending <= 1'b0;
        end else if (rom_cs && !rom_pending) begin
            rom_pending <= 1'b1;
            rom_wait    <= rom_delay;
        end else if (rom_pending) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic compare_selects(input region_e r, input logic rom_exp);
        check("gfx1_cs", 32'(gfx1_cs), 32'(r == reg_gfx1));
        check("gfx2_cs", 32'(gfx2_cs), 32'(r == reg_gfx2));
        check("pal_cs", 32'(pal_cs), 32'(r == reg_pal));
        check("rom_cs", 32'(rom_cs), 32'(rom_exp));
    endtask

    task automatic randomize_inputs();
        start_button <= 2'($urandom);
        coin_input   <= 2'($urandom);
        service      <= 1'($urandom);
        joystick1    <= 6'($urandom);
        joystick2    <= 6'($urandom);
        dip_pause    <= 1'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
        dipsw_c      <= 4'($urandom);
        gfx1_dout    <= 8'($urandom);
        gfx2_dout    <= 8'($urandom);
        pal_dout     <= 8'($urandom);
    endtask

    // One Wishbone cycle checked at ack and in the cycle after
    task automatic bus_cycle(input logic [15:0] a, input logic we, input logic [7:0] d);
        region_e     r;
        logic        rom_side;
        logic [17:0] exp_ra;
        int          dly;
        int          lat;
        r        = addr_region(a);
        rom_side = (r == reg_rom_bank || r == reg_rom_fix);
        exp_ra   = map_rom_addr(a, bank_m);
        dly      = $urandom_range(0, 5);
        lat      = 0;
        @(posedge clk);
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= we;
        wb_adr    <= a;
        wb_dat_w  <= d;
        rom_delay <= dly;
        randomize_inputs();
        @(negedge clk);
        while (wb_ack !== 1'b1) begin
            check("snd_irq", 32'(snd_irq), 32'(1'b0));
            if (lat > 0)
                compare_selects(r, rom_side);
            @(negedge clk);
            lat = lat + 1;
        end
        // ROM adds the responder wait plus request and data registers
        check("wb_ack latency", 32'(lat), 32'(rom_side ? dly + 4 : 2));
        compare_selects(r, 1'b0);
        check("cpu_addr", 32'(cpu_addr), 32'(a));
        check("cpu_rnw", 32'(cpu_rnw), 32'(!we));
        check("cpu_dout", 32'(cpu_dout), 32'(d));
        if (rom_side)
            check("rom_addr", 32'(rom_addr), 32'(exp_ra));
        if (we)
            record_write(a, d);
        else
            check("wb_dat_r", 32'(wb_dat_r), 32'(predict_read(a)));
        check("snd_latch", 32'(snd_latch), 32'(snd_m));
        check("video_bank", 32'(video_bank), 32'(vbank_m));
        check("prio_latch", 32'(prio_latch), 32'(prio_m));
        check("irq", 32'(irq), 32'(irq_m));
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        check("wb_ack", 32'(wb_ack), 32'(1'b0));
        check("snd_irq", 32'(snd_irq), 32'(we && r == reg_io && a[3:0] == 4'h8));
        compare_selects(reg_none, 1'b0);
    endtask

    // Falling edge on gfx_irqn counts only while pause is high
    task automatic vblank_edge();
        logic pause;
        pause = 1'($urandom);
        @(posedge clk);
        dip_pause <= pause;
        gfx_irqn  <= 1'b0;
        @(posedge clk);
        gfx_irqn <= 1'b1;
        if (pause)
            irq_m = 1'b1;
        @(negedge clk);
        check("irq", 32'(irq), 32'(irq_m));
        check("snd_irq", 32'(snd_irq), 32'(1'b0));
    endtask

    initial begin
        int          kind;
        logic        we;
        logic [7:0]  d;
        logic [15:0] a;
        void'($urandom(32'hb67e6542));
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 16'h0000;
        wb_dat_w  = 8'h00;
        rom_delay = 0;
        gfx_irqn  = 1'b1;
        start_button = 2'b00;
        coin_input   = 2'b00;
        joystick1    = 6'h00;
        joystick2    = 6'h00;
        service      = 1'b0;
        dip_pause    = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        dipsw_c      = 4'h0;
        gfx1_dout    = 8'h00;
        gfx2_dout    = 8'h00;
        pal_dout     = 8'h00;
        reset_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("wb_ack", 32'(wb_ack), 32'(1'b0));
        check("snd_irq", 32'(snd_irq), 32'(1'b0));
        check("irq", 32'(irq), 32'(1'b0));
        check("video_bank", 32'(video_bank), 32'(8'h00));
        check("prio_latch", 32'(prio_latch), 32'(1'b0));
        compare_selects(reg_none, 1'b0);
        for (int i = 0; i < n_trans; i++) begin
            kind = $urandom_range(0, 8);
            we   = 1'($urandom);
            d    = 8'($urandom);
            a    = 16'h0000;
            if (kind == 8) begin
                // Acknowledge a pending interrupt so each edge starts from a clear irq
                if (irq_m)
                    bus_cycle(16'h000C, 1'b1, d);
                vblank_edge();
            end else begin
                case (kind)
                    // I/O writes aim at the latch offsets
                    0: a = we ? 16'(8 + $urandom_range(0, 4)) : 16'($urandom_range(0, 15));
                    1: a = 16'($urandom_range(16'h0010, 16'h07FF));
                    2: a = 16'($urandom_range(16'h0800, 16'h0FFF));
                    3: a = 16'($urandom_range(16'h1000, 16'h10FF));
                    4, 5: begin
                        if (!we && ram_used.size() > 0) begin
                            a = ram_used[$urandom_range(0, ram_used.size() - 1)];
                        end else begin
                            we = 1'b1;
                            a  = 16'h1800 + 16'($urandom_range(0, 4095));
                        end
                    end
                    6: a = 16'($urandom_range(16'h4000, 16'hFFFF));
                    default: begin
                        if (1'($urandom))
                            a = 16'($urandom_range(16'h1100, 16'h17FF));
                        else
                            a = 16'($urandom_range(16'h2800, 16'h3FFF));
                    end
                endcase
                bus_cycle(a, we, d);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- hdl/main_top.sv
// Main board top level with decoder, work RAM and I/O block
`timescale 1ns/1ns

module main_top (
    input  logic                                clk,
    input  logic                                rst,
    // CPU bus
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [main_map_pkg::addr_w-1:0]     wb_adr,
    input  logic [main_map_pkg::data_w-1:0]     wb_dat_w,
    output logic [main_map_pkg::data_w-1:0]     wb_dat_r,
    output logic                                wb_ack,
    // Sound CPU
    output logic                                snd_irq,
    output logic [main_map_pkg::data_w-1:0]     snd_latch,
    // ROM
    output logic [main_map_pkg::rom_aw-1:0]     rom_addr,
    output logic                                rom_cs,
    input  logic [main_map_pkg::data_w-1:0]     rom_data,
    input  logic                                rom_ok,
    // Cabinet
    input  logic [1:0]                          start_button,
    input  logic [1:0]                          coin_input,
    input  logic [5:0]                          joystick1,
    input  logic [5:0]                          joystick2,
    input  logic                                service,
    // Video chips
    output logic [main_map_pkg::addr_w-1:0]     cpu_addr,
    output logic                                cpu_rnw,
    output logic [main_map_pkg::data_w-1:0]     cpu_dout,
    input  logic                                gfx_irqn,
    output logic                                gfx1_cs,
    output logic                                gfx2_cs,
    output logic                                pal_cs,
    output logic [main_map_pkg::data_w-1:0]     video_bank,
    output logic                                prio_latch,
    input  logic [main_map_pkg::data_w-1:0]     gfx1_dout,
    input  logic [main_map_pkg::data_w-1:0]     gfx2_dout,
    input  logic [main_map_pkg::data_w-1:0]     pal_dout,
    output logic                                irq,
    // DIP switches
    input  logic                                dip_pause,
    input  logic [7:0]                          dipsw_a,
    input  logic [7:0]                          dipsw_b,
    input  logic [3:0]                          dipsw_c
);
    import main_map_pkg::*;
    import main_io_pkg::*;

    cabinet_t              cab;
    dip_t                  dip;
    logic [rom_bank_w-1:0] rom_bank;

    main_bus_if ram_bus();
    main_bus_if io_bus();

    assign cab.start   = start_button;
    assign cab.coin    = coin_input;
    assign cab.service = service;
    assign cab.joy1    = joystick1;
    assign cab.joy2    = joystick2;
    assign cab.pad     = 1'b0;

    assign dip.dip_a = dipsw_a;
    assign dip.dip_b = dipsw_b;
    assign dip.dip_c = dipsw_c;
    assign dip.pause = dip_pause;

    // Video chips watch the CPU bus directly
    assign cpu_addr = wb_adr;
    assign cpu_rnw  = !wb_we;
    assign cpu_dout = wb_dat_w;

    main_decoder u_decoder (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .wb_cyc    ( wb_cyc    ),
        .wb_stb    ( wb_stb    ),
        .wb_we     ( wb_we     ),
        .wb_adr    ( wb_adr    ),
        .wb_dat_w  ( wb_dat_w  ),
        .wb_dat_r  ( wb_dat_r  ),
        .wb_ack    ( wb_ack    ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .rom_bank  ( rom_bank  ),
        .gfx1_cs   ( gfx1_cs   ),
        .gfx2_cs   ( gfx2_cs   ),
        .pal_cs    ( pal_cs    ),
        .gfx1_dout ( gfx1_dout ),
        .gfx2_dout ( gfx2_dout ),
        .pal_dout  ( pal_dout  ),
        .ram_bus   ( ram_bus   ),
        .io_bus    ( io_bus    )
    );

    main_ram u_ram (
        .clk ( clk     ),
        .rst ( rst     ),
        .bus ( ram_bus )
    );

    main_io u_io (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cab        ( cab        ),
        .dip        ( dip        ),
        .gfx_irqn   ( gfx_irqn   ),
        .bus        ( io_bus     ),
        .snd_latch  ( snd_latch  ),
        .snd_irq    ( snd_irq    ),
        .video_bank ( video_bank ),
        .prio_latch ( prio_latch ),
        .rom_bank   ( rom_bank   ),
        .irq        ( irq        )
    );

endmodule

//--- hdl/main_io.sv
// Input port reads, output latches, sound interrupt and vblank interrupt
`timescale 1ns/1ns

module main_io (
    input  logic                                clk,
    input  logic                                rst,
    input  main_io_pkg::cabinet_t               cab,
    input  main_io_pkg::dip_t                   dip,
    input  logic                                gfx_irqn,
    main_bus_if.slave                           bus,
    output logic [main_map_pkg::data_w-1:0]     snd_latch,
    output logic                                snd_irq,
    output logic [main_map_pkg::data_w-1:0]     video_bank,
    output logic                                prio_latch,
    output logic [main_map_pkg::rom_bank_w-1:0] rom_bank,
    output logic                                irq
);
    import main_map_pkg::*;
    import main_io_pkg::*;

    logic [io_off_w-1:0] offs;
    logic [data_w-1:0]   rd_data;
    logic                wr;
    logic                irqn_q;
    logic                irq_fall;

    assign offs = bus.adr[io_off_w-1:0];
    assign wr   = bus.stb && bus.we;

    always_comb begin
        case (offs)
            io_rd_sys:  rd_data = sys_byte(cab);
            io_rd_joy1: rd_data = joy_byte(cab.joy1);
            io_rd_joy2: rd_data = joy_byte(cab.joy2);
            io_rd_dipa: rd_data = dip.dip_a;
            io_rd_dipb: rd_data = dip.dip_b;
            io_rd_dipc: rd_data = {4'hF, dip.dip_c};
            default:    rd_data = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.stb)
            bus.dat_r <= rd_data;
    end

    // Latches change at the strobe so the new value shows in the ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack    <= 1'b0;
            snd_latch  <= '0;
            snd_irq    <= 1'b0;
            video_bank <= '0;
            prio_latch <= 1'b0;
            rom_bank   <= '0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;
            // Sound CPU gets its pulse right after the ack
            snd_irq <= bus.ack && bus.we && offs == io_wr_snd;
            if (wr) begin
                case (offs)
                    io_wr_snd:   snd_latch  <= bus.dat_w;
                    io_wr_vbank: video_bank <= bus.dat_w;
                    io_wr_prio:  prio_latch <= bus.dat_w[0];
                    io_wr_bank:  rom_bank   <= bus.dat_w[rom_bank_w-1:0];
                    default:     ;
                endcase
            end
        end
    end

    // Vblank edge detect, masked while paused
    assign irq_fall = irqn_q && !gfx_irqn && dip.pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irqn_q <= 1'b1;
            irq    <= 1'b0;
        end else begin
            irqn_q <= gfx_irqn;
            // A fresh edge wins over an acknowledge in the same cycle
            if (irq_fall)
                irq <= 1'b1;
            else if (wr && offs == io_wr_iack)
                irq <= 1'b0;
        end
    end

endmodule

//--- hdl/main_ram.sv
// Work RAM slave with registered read and single cycle ack
`timescale 1ns/1ns

module main_ram (
    input  logic       clk,
    input  logic       rst,
    main_bus_if.slave  bus
);
    import main_map_pkg::*;

    logic [data_w-1:0] mem [0:(1 << ram_aw)-1];
    logic [ram_aw-1:0] idx;

    // Low address bits fold the 0x1800 window onto the array
    assign idx = bus.adr[ram_aw-1:0];

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            if (bus.we)
                mem[idx] <= bus.dat_w;
            bus.dat_r <= mem[idx];
        end
    end

    // One ack per strobe
    always_ff @(posedge clk) begin
        if (rst)
            bus.ack <= 1'b0;
        else
            bus.ack <= bus.stb && !bus.ack;
    end

endmodule

//--- hdl/main_decoder.sv
// Address decoder with ROM banking, chip selects, read mux and Wishbone ack
`timescale 1ns/1ns

module main_decoder (
    input  logic                                clk,
    input  logic                                rst,
    // CPU side
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [main_map_pkg::addr_w-1:0]     wb_adr,
    input  logic [main_map_pkg::data_w-1:0]     wb_dat_w,
    output logic [main_map_pkg::data_w-1:0]     wb_dat_r,
    output logic                                wb_ack,
    // ROM
    output logic [main_map_pkg::rom_aw-1:0]     rom_addr,
    output logic                                rom_cs,
    input  logic [main_map_pkg::data_w-1:0]     rom_data,
    input  logic                                rom_ok,
    input  logic [main_map_pkg::rom_bank_w-1:0] rom_bank,
    // External chips
    output logic                                gfx1_cs,
    output logic                                gfx2_cs,
    output logic                                pal_cs,
    input  logic [main_map_pkg::data_w-1:0]     gfx1_dout,
    input  logic [main_map_pkg::data_w-1:0]     gfx2_dout,
    input  logic [main_map_pkg::data_w-1:0]     pal_dout,
    main_bus_if.master                          ram_bus,
    main_bus_if.master                          io_bus
);
    import main_map_pkg::*;

    region_e           region_d;
    region_e           region_q;
    logic              busy;
    logic              start;
    logic              own_stb;
    logic              own_ack;
    logic              rom_ack;
    logic              rom_hit;
    logic [data_w-1:0] rom_q;
    logic [rom_aw-1:0] rom_addr_d;

    function automatic region_e decode_region(input logic [addr_w-1:0] a);
        if (a <= io_last)
            return reg_io;
        else if (a <= gfx1_last)
            return reg_gfx1;
        else if (a <= gfx2_last)
            return reg_gfx2;
        else if (a >= pal_first && a <= pal_last)
            return reg_pal;
        else if (a >= ram_first && a <= ram_last)
            return reg_ram;
        else if (a >= rom_fix_first)
            return reg_rom_fix;
        else if (a >= rom_bank_first)
            return reg_rom_bank;
        return reg_none;
    endfunction

    // A new cycle starts only when nothing else is in flight
    assign start    = wb_cyc && wb_stb && !busy;
    assign region_d = decode_region(wb_adr);
    assign rom_hit  = rom_cs && rom_ok;

    always_comb begin
        if (region_d == reg_rom_bank)
            rom_addr_d = rom_bank_base + rom_aw'({rom_bank, wb_adr[rom_win_w-1:0]});
        else
            rom_addr_d = rom_aw'(wb_adr);
    end

    // Slaves latch address and data while the CPU holds them
    assign ram_bus.adr   = wb_adr;
    assign ram_bus.dat_w = wb_dat_w;
    assign ram_bus.we    = wb_we;
    assign io_bus.adr    = wb_adr;
    assign io_bus.dat_w  = wb_dat_w;
    assign io_bus.we     = wb_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            region_q    <= reg_none;
            ram_bus.stb <= 1'b0;
            io_bus.stb  <= 1'b0;
            own_stb     <= 1'b0;
            own_ack     <= 1'b0;
            rom_ack     <= 1'b0;
            rom_cs      <= 1'b0;
            gfx1_cs     <= 1'b0;
            gfx2_cs     <= 1'b0;
            pal_cs      <= 1'b0;
        end else begin
            ram_bus.stb <= start && region_d == reg_ram;
            io_bus.stb  <= start && region_d == reg_io;
            // External chips and holes get a fixed one cycle wait
            own_stb <= start && (region_d == reg_gfx1 || region_d == reg_gfx2 ||
                                 region_d == reg_pal  || region_d == reg_none);
            own_ack <= own_stb;
            rom_ack <= rom_hit;
            if (start) begin
                busy     <= 1'b1;
                region_q <= region_d;
                rom_cs   <= region_d == reg_rom_bank || region_d == reg_rom_fix;
                gfx1_cs  <= region_d == reg_gfx1;
                gfx2_cs  <= region_d == reg_gfx2;
                pal_cs   <= region_d == reg_pal;
            end else begin
                if (rom_hit)
                    rom_cs <= 1'b0;
                if (wb_ack) begin
                    busy    <= 1'b0;
                    gfx1_cs <= 1'b0;
                    gfx2_cs <= 1'b0;
                    pal_cs  <= 1'b0;
                end
            end
        end
    end

    // ROM address held for the whole fetch
    always_ff @(posedge clk) begin
        if (start)
            rom_addr <= rom_addr_d;
        if (rom_hit)
            rom_q <= rom_data;
    end

    assign wb_ack = ram_bus.ack || io_bus.ack || own_ack || rom_ack;

    always_comb begin
        case (region_q)
            reg_io:       wb_dat_r = io_bus.dat_r;
            reg_ram:      wb_dat_r = ram_bus.dat_r;
            reg_gfx1:     wb_dat_r = gfx1_dout;
            reg_gfx2:     wb_dat_r = gfx2_dout;
            reg_pal:      wb_dat_r = pal_dout;
            reg_rom_bank: wb_dat_r = rom_q;
            reg_rom_fix:  wb_dat_r = rom_q;
            default:      wb_dat_r = 8'hFF;
        endcase
    end

endmodule

//--- hdl/main_bus_if.sv
// Decoder to slave bus with master and slave views
`timescale 1ns/1ns

interface main_bus_if;
    import main_map_pkg::*;

    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat_w;
    logic              we;
    logic              stb;
    logic [data_w-1:0] dat_r;
    logic              ack;

    // Decoder side
    modport master (
        output adr, dat_w, we, stb,
        input  dat_r, ack
    );

    // Slave sees a one cycle strobe and answers one cycle later
    modport slave (
        input  adr, dat_w, we, stb,
        output dat_r, ack
    );

endinterface

//--- hdl/main_io_pkg.sv
// Cabinet input and DIP switch structs with the input port byte layouts
package main_io_pkg;

    typedef struct packed {
        logic       pad;
        logic [5:0] joy2;
        logic [5:0] joy1;
        logic       service;
        logic [1:0] coin;
        logic [1:0] start;
    } cabinet_t;

    typedef struct packed {
        logic       pause;
        logic [3:0] dip_c;
        logic [7:0] dip_b;
        logic [7:0] dip_a;
    } dip_t;

    // Coin in 1:0, start in 3:2, service in 4, unused bits read as ones
    function automatic logic [7:0] sys_byte(input cabinet_t c);
        return {3'b111, c.service, c.start, c.coin};
    endfunction

    // Joysticks are six bits wide, top two bits float high
    function automatic logic [7:0] joy_byte(input logic [5:0] j);
        return {2'b11, j};
    endfunction

endpackage

//--- hdl/main_map_pkg.sv
// CPU bus widths, memory map bounds, region codes, ROM banking and I/O offsets
package main_map_pkg;

    localparam int addr_w     = 16;
    localparam int data_w     = 8;
    localparam int rom_aw     = 18;
    localparam int ram_aw     = 12;
    localparam int rom_bank_w = 4;
    localparam int rom_win_w  = 13;
    localparam int io_off_w   = 4;

    typedef enum logic [2:0] {
        reg_io,
        reg_gfx1,
        reg_gfx2,
        reg_pal,
        reg_ram,
        reg_rom_bank,
        reg_rom_fix,
        reg_none
    } region_e;

    // Region bounds, I/O starts at address zero
    localparam logic [addr_w-1:0] io_last        = 16'h000F;
    localparam logic [addr_w-1:0] gfx1_last      = 16'h07FF;
    localparam logic [addr_w-1:0] gfx2_last      = 16'h0FFF;
    localparam logic [addr_w-1:0] pal_first      = 16'h1000;
    localparam logic [addr_w-1:0] pal_last       = 16'h10FF;
    localparam logic [addr_w-1:0] ram_first      = 16'h1800;
    localparam logic [addr_w-1:0] ram_last       = 16'h27FF;
    localparam logic [addr_w-1:0] rom_bank_first = 16'h4000;
    localparam logic [addr_w-1:0] rom_fix_first  = 16'h6000;

    // Banked window lands above the fixed ROM image
    localparam logic [rom_aw-1:0] rom_bank_base = 18'h10000;

    localparam logic [io_off_w-1:0] io_rd_sys   = 4'h0;
    localparam logic [io_off_w-1:0] io_rd_joy1  = 4'h1;
    localparam logic [io_off_w-1:0] io_rd_joy2  = 4'h2;
    localparam logic [io_off_w-1:0] io_rd_dipa  = 4'h3;
    localparam logic [io_off_w-1:0] io_rd_dipb  = 4'h4;
    localparam logic [io_off_w-1:0] io_rd_dipc  = 4'h5;
    localparam logic [io_off_w-1:0] io_wr_snd   = 4'h8;
    localparam logic [io_off_w-1:0] io_wr_vbank = 4'h9;
    localparam logic [io_off_w-1:0] io_wr_prio  = 4'hA;
    localparam logic [io_off_w-1:0] io_wr_bank  = 4'hB;
    localparam logic [io_off_w-1:0] io_wr_iack  = 4'hC;

endpackage
